// File: files.f
common/dispatch_pkg.sv
dispatch/issue_arbiter.sv
dispatch/operand_forward.sv
dispatch/load_use_detect.sv
dispatch/dispatch_stage_reg.sv
dispatch/dispatch_top.sv
sim/dispatch_properties.sv
sim/dispatch_tb.sv

// File: Makefile
# Verilator build and run for the dispatch stage testbench

VERILATOR  ?= verilator
TOP        ?= dispatch_tb
RTL_TOP    ?= dispatch_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "ERRORS FOUND" $(LOG) || ! grep -qx "NO ERRORS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/dispatch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_tb
    import dispatch_pkg::*;
();

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 4;
    localparam int          NUM_CYCLES   = 2000;
    localparam int          TEST_NS      = (RESET_CYCLES + NUM_CYCLES + 2) * CLK_PERIOD;
    localparam int unsigned SEED         = 32'h91b1_1c83;

    logic clk, reset_i, pause_i, flush_i, ex_pause_i;
    word_t      [NUM_SLOTS-1:0]      pc_i, inst_i, imm_i;
    slot_mask_t                      valid_i, reg_write_en_i, is_privilege_i, is_cnt_i;
    alu_op_t    [NUM_SLOTS-1:0]      alu_op_i, ex_alu_op_i;
    alu_sel_t   [NUM_SLOTS-1:0]      alu_sel_i;
    logic       [NUM_SLOTS-1:0][1:0] reg_read_en_i;
    reg_addr_t  [NUM_SLOTS-1:0][1:0] reg_read_addr_i;
    reg_addr_t  [NUM_SLOTS-1:0]      reg_write_addr_i, ex_addr_i, mem_addr_i, wb_addr_i;
    slot_mask_t                      ex_we_i, mem_we_i, wb_we_i;
    word_t      [NUM_SLOTS-1:0]      ex_data_i, mem_data_i, wb_data_i;
    word_t      [3:0]                rf_data_i;
    slot_mask_t                      issue_en_o, valid_o, reg_write_en_o;
    logic                            load_use_stall_o;
    word_t      [NUM_SLOTS-1:0]      pc_o, inst_o;
    alu_op_t    [NUM_SLOTS-1:0]      alu_op_o;
    alu_sel_t   [NUM_SLOTS-1:0]      alu_sel_o;
    reg_addr_t  [NUM_SLOTS-1:0]      reg_write_addr_o;
    word_t      [3:0]                operand_o;

    // expected contents of the execute-facing register
    word_t      [NUM_SLOTS-1:0] exp_pc, exp_inst;
    slot_mask_t                 exp_valid, exp_we;
    alu_op_t    [NUM_SLOTS-1:0] exp_op;
    alu_sel_t   [NUM_SLOTS-1:0] exp_sel;
    reg_addr_t  [NUM_SLOTS-1:0] exp_waddr;
    word_t      [3:0]           exp_operand;

    dispatch_top u_dispatch_top (.*);

    bind dispatch_top dispatch_properties u_properties (
        .clk(clk), .reset_i(reset_i), .flush_i(flush_i), .pause_i(pause_i),
        .ex_pause_i(ex_pause_i), .valid_i(valid_i), .issue_en_i(issue_en_o),
        .load_use_i(load_use_stall_o), .out_valid_i(valid_o),
        .out_reg_write_en_i(reg_write_en_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error %s expected %h got %h", name, exp, got);
            $display("ERRORS FOUND");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic reg_addr_t rand_addr();
        if ($urandom_range(7, 0) != 0) begin
            return reg_addr_t'($urandom_range(3, 0));  // crowd r0..r3
        end
        return reg_addr_t'($urandom);
    endfunction

    function automatic alu_op_t rand_ex_op();
        if ($urandom_range(7, 0) != 0) begin
            return alu_op_t'($urandom);
        end
        case ($urandom_range(6, 0))
            0:       return ALU_LD_B;
            1:       return ALU_LD_H;
            2:       return ALU_LD_W;
            3:       return ALU_LD_BU;
            4:       return ALU_LD_HU;
            5:       return ALU_LL_W;
            default: return ALU_SC_W;
        endcase
    endfunction

    function automatic slot_mask_t model_issue();
        logic dual;
        dual = valid_i[0] && valid_i[1];
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (alu_sel_i[s] == ALU_SEL_LOAD_STORE || is_privilege_i[s] || is_cnt_i[s]) begin
                dual = 1'b0;
            end
        end
        for (int r = 0; r < 2; r++) begin
            if (reg_write_en_i[0] && reg_write_addr_i[0] != 5'd0 && reg_read_en_i[1][r]
                    && reg_read_addr_i[1][r] == reg_write_addr_i[0]) begin
                dual = 1'b0;  // slot 1 reads what slot 0 writes
            end
        end
        return dual ? 2'b11 : valid_i[0] ? 2'b01 : valid_i[1] ? 2'b10 : 2'b00;
    endfunction

    function automatic logic model_load_use();
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            for (int r = 0; r < 2; r++) begin
                if (reg_read_en_i[s][r] && reg_read_addr_i[s][r] == ex_addr_i[0]) begin
                    hit = 1'b1;
                end
            end
        end
        return hit && (is_load_op(ex_alu_op_i[0]) || is_load_op(ex_alu_op_i[1]));
    endfunction

    function automatic word_t take_newer(input word_t cur, input slot_mask_t we,
                                         input reg_addr_t [NUM_SLOTS-1:0] addr,
                                         input word_t [NUM_SLOTS-1:0] data,
                                         input reg_addr_t a);
        word_t val;
        val = cur;
        for (int e = NUM_SLOTS - 1; e >= 0; e--) begin
            if (we[e] && addr[e] == a) begin
                val = data[e];  // entry 0 is written last and wins
            end
        end
        return val;
    endfunction

    function automatic word_t model_operand(input int s, input int r);
        reg_addr_t a;
        word_t val;
        a   = reg_read_addr_i[s][r];
        val = rf_data_i[2*s + r];
        // oldest stage first so younger results overwrite
        val = take_newer(val, wb_we_i, wb_addr_i, wb_data_i, a);
        val = take_newer(val, mem_we_i, mem_addr_i, mem_data_i, a);
        val = take_newer(val, ex_we_i, ex_addr_i, ex_data_i, a);
        if (a == 5'd0) begin
            val = '0;
        end
        if (!reg_read_en_i[s][r]) begin
            val = imm_i[s];
        end
        return val;
    endfunction

    task automatic clear_model();
        exp_pc      = '0;
        exp_inst    = '0;
        exp_valid   = '0;
        exp_we      = '0;
        exp_op      = '0;
        exp_sel     = '0;
        exp_waddr   = '0;
        exp_operand = '0;
    endtask

    task automatic step_model();
        slot_mask_t issue;
        issue = model_issue();
        if (reset_i || flush_i || (model_load_use() && !ex_pause_i)) begin
            clear_model();
        end else if (!pause_i) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                exp_pc[s]    = issue[s] ? pc_i[s] : '0;
                exp_inst[s]  = issue[s] ? inst_i[s] : '0;
                exp_valid[s] = issue[s] && valid_i[s];
                exp_we[s]    = issue[s] && reg_write_en_i[s];
                exp_op[s]    = issue[s] ? alu_op_i[s] : '0;
                exp_sel[s]   = issue[s] ? alu_sel_i[s] : '0;
                exp_waddr[s] = issue[s] ? reg_write_addr_i[s] : '0;
                for (int r = 0; r < 2; r++) begin
                    exp_operand[2*s + r] = issue[s] ? model_operand(s, r) : '0;
                end
            end
        end
    endtask

    task automatic check_comb();
        slot_mask_t exp_issue;
        exp_issue = pause_i ? 2'b00 : model_issue();
        check_value("issue_en_o", 32'(issue_en_o), 32'(exp_issue));
        check_value("load_use_stall_o", 32'(load_use_stall_o), 32'(model_load_use()));
    endtask

    task automatic check_registered();
        for (int s = 0; s < NUM_SLOTS; s++) begin
            check_value($sformatf("pc_o[%0d]", s), pc_o[s], exp_pc[s]);
            check_value($sformatf("inst_o[%0d]", s), inst_o[s], exp_inst[s]);
            check_value($sformatf("valid_o[%0d]", s), 32'(valid_o[s]), 32'(exp_valid[s]));
            check_value($sformatf("reg_write_en_o[%0d]", s), 32'(reg_write_en_o[s]),
                        32'(exp_we[s]));
            check_value($sformatf("alu_op_o[%0d]", s), 32'(alu_op_o[s]), 32'(exp_op[s]));
            check_value($sformatf("alu_sel_o[%0d]", s), 32'(alu_sel_o[s]), 32'(exp_sel[s]));
            check_value($sformatf("reg_write_addr_o[%0d]", s), 32'(reg_write_addr_o[s]),
                        32'(exp_waddr[s]));
        end
        for (int i = 0; i < 4; i++) begin
            check_value($sformatf("operand_o[%0d]", i), operand_o[i], exp_operand[i]);
        end
    endtask

    task automatic init_inputs();
        reset_i          = 1'b1;
        pause_i          = 1'b0;
        flush_i          = 1'b0;
        ex_pause_i       = 1'b0;
        pc_i             = '0;
        inst_i           = '0;
        imm_i            = '0;
        valid_i          = '0;
        alu_op_i         = '0;
        alu_sel_i        = '0;
        reg_read_en_i    = '0;
        reg_read_addr_i  = '0;
        reg_write_en_i   = '0;
        reg_write_addr_i = '0;
        is_privilege_i   = '0;
        is_cnt_i         = '0;
        ex_we_i          = '0;
        ex_addr_i        = '0;
        ex_data_i        = '0;
        mem_we_i         = '0;
        mem_addr_i       = '0;
        mem_data_i       = '0;
        wb_we_i          = '0;
        wb_addr_i        = '0;
        wb_data_i        = '0;
        ex_alu_op_i      = '0;
        rf_data_i        = '0;
    endtask

    task automatic drive_inputs();
        pause_i        = ($urandom_range(15, 0) == 0);  // control levels stay rare
        flush_i        = ($urandom_range(39, 0) == 0);
        ex_pause_i     = ($urandom_range(15, 0) == 0);
        reg_write_en_i = slot_mask_t'($urandom);
        ex_we_i        = slot_mask_t'($urandom);
        mem_we_i       = slot_mask_t'($urandom);
        wb_we_i        = slot_mask_t'($urandom);
        for (int s = 0; s < NUM_SLOTS; s++) begin
            pc_i[s]             = $urandom;
            inst_i[s]           = $urandom;
            imm_i[s]            = $urandom;
            valid_i[s]          = ($urandom_range(7, 0) != 0);
            alu_op_i[s]         = alu_op_t'($urandom);
            alu_sel_i[s]        = alu_sel_t'($urandom);
            is_privilege_i[s]   = ($urandom_range(15, 0) == 0);
            is_cnt_i[s]         = ($urandom_range(15, 0) == 0);
            reg_write_addr_i[s] = rand_addr();
            ex_alu_op_i[s]      = rand_ex_op();
            ex_addr_i[s]        = rand_addr();
            mem_addr_i[s]       = rand_addr();
            wb_addr_i[s]        = rand_addr();
            ex_data_i[s]        = $urandom;
            mem_data_i[s]       = $urandom;
            wb_data_i[s]        = $urandom;
            for (int r = 0; r < 2; r++) begin
                reg_read_en_i[s][r]   = ($urandom_range(3, 0) != 0);
                reg_read_addr_i[s][r] = rand_addr();
            end
        end
        for (int i = 0; i < 4; i++) begin
            rf_data_i[i] = $urandom;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        init_inputs();
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_registered();
        reset_i = 1'b0;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            drive_inputs();
            #4;
            check_comb();
            step_model();
            @(posedge clk);
            #1;
            check_registered();
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(2 * TEST_NS);
        $display("timeout after %0d ns, the test loop did not finish", 2 * TEST_NS);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: sim/dispatch_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_properties
    import dispatch_pkg::*;
(
    input logic       clk,
    input logic       reset_i,
    input logic       flush_i,
    input logic       pause_i,
    input logic       ex_pause_i,
    input slot_mask_t valid_i,
    input slot_mask_t issue_en_i,          // gated issue back to decode
    input logic       load_use_i,
    input slot_mask_t out_valid_i,         // registered toward execute
    input slot_mask_t out_reg_write_en_i
);

    a_reset_clears: assert property (@(posedge clk)
        reset_i |=> (out_valid_i == '0 && out_reg_write_en_i == '0))
        else $error("registered slots still active after reset");

    a_flush_clears: assert property (@(posedge clk) disable iff (reset_i)
        flush_i |=> (out_valid_i == '0 && out_reg_write_en_i == '0))
        else $error("registered slots still active after flush");

    // bubble toward execute when the load result is not ready
    a_load_use_bubble: assert property (@(posedge clk) disable iff (reset_i)
        (load_use_i && !ex_pause_i) |=> (out_valid_i == '0))
        else $error("load-use stall did not insert a bubble");

    a_pause_holds: assert property (@(posedge clk) disable iff (reset_i)
        (pause_i && !flush_i && !(load_use_i && !ex_pause_i))
            |=> ($stable(out_valid_i) && $stable(out_reg_write_en_i)))
        else $error("registered slots changed while paused");

    // only a slot that issued may show up valid toward execute
    a_idle_slot_clears: assert property (@(posedge clk) disable iff (reset_i)
        !pause_i |=> ((out_valid_i & ~$past(issue_en_i & valid_i)) == '0))
        else $error("registered slot valid without an issued instruction");

endmodule

`default_nettype wire

// File: dispatch/dispatch_top.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_top
    import dispatch_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             pause_i,
    input  logic                             flush_i,
    input  logic                             ex_pause_i,
    input  word_t      [NUM_SLOTS-1:0]       pc_i,
    input  word_t      [NUM_SLOTS-1:0]       inst_i,
    input  slot_mask_t                       valid_i,
    input  alu_op_t    [NUM_SLOTS-1:0]       alu_op_i,
    input  alu_sel_t   [NUM_SLOTS-1:0]       alu_sel_i,
    input  word_t      [NUM_SLOTS-1:0]       imm_i,
    input  logic       [NUM_SLOTS-1:0][1:0]  reg_read_en_i,    // [slot][source]
    input  reg_addr_t  [NUM_SLOTS-1:0][1:0]  reg_read_addr_i,
    input  slot_mask_t                       reg_write_en_i,
    input  reg_addr_t  [NUM_SLOTS-1:0]       reg_write_addr_i,
    input  slot_mask_t                       is_privilege_i,
    input  slot_mask_t                       is_cnt_i,
    input  slot_mask_t                       ex_we_i,
    input  reg_addr_t  [NUM_SLOTS-1:0]       ex_addr_i,
    input  word_t      [NUM_SLOTS-1:0]       ex_data_i,
    input  slot_mask_t                       mem_we_i,
    input  reg_addr_t  [NUM_SLOTS-1:0]       mem_addr_i,
    input  word_t      [NUM_SLOTS-1:0]       mem_data_i,
    input  slot_mask_t                       wb_we_i,
    input  reg_addr_t  [NUM_SLOTS-1:0]       wb_addr_i,
    input  word_t      [NUM_SLOTS-1:0]       wb_data_i,
    input  alu_op_t    [NUM_SLOTS-1:0]       ex_alu_op_i,
    input  word_t      [3:0]                 rf_data_i,        // slot*2 + source
    output slot_mask_t                       issue_en_o,       // back to decode
    output logic                             load_use_stall_o,
    output word_t      [NUM_SLOTS-1:0]       pc_o,
    output word_t      [NUM_SLOTS-1:0]       inst_o,
    output slot_mask_t                       valid_o,
    output alu_op_t    [NUM_SLOTS-1:0]       alu_op_o,
    output alu_sel_t   [NUM_SLOTS-1:0]       alu_sel_o,
    output slot_mask_t                       reg_write_en_o,
    output reg_addr_t  [NUM_SLOTS-1:0]       reg_write_addr_o,
    output word_t      [3:0]                 operand_o
);

    slot_mask_t issue_en;
    word_t [3:0] operand;
    logic load_use;

    assign issue_en_o       = pause_i ? '0 : issue_en;  // decode must not advance while paused
    assign load_use_stall_o = load_use;

    issue_arbiter u_arbiter (
        .valid_i(valid_i), .alu_sel_i(alu_sel_i),
        .reg_write_en_i(reg_write_en_i), .reg_write_addr_i(reg_write_addr_i),
        .slot1_read_en_i(reg_read_en_i[1]), .slot1_read_addr_i(reg_read_addr_i[1]),
        .is_privilege_i(is_privilege_i), .is_cnt_i(is_cnt_i), .issue_en_o(issue_en)
    );

    operand_forward u_fwd_0_0 (
        .read_en_i(reg_read_en_i[0][0]), .read_addr_i(reg_read_addr_i[0][0]),
        .rf_data_i(rf_data_i[0]), .imm_i(imm_i[0]),
        .ex_we_i(ex_we_i), .ex_addr_i(ex_addr_i), .ex_data_i(ex_data_i),
        .mem_we_i(mem_we_i), .mem_addr_i(mem_addr_i), .mem_data_i(mem_data_i),
        .wb_we_i(wb_we_i), .wb_addr_i(wb_addr_i), .wb_data_i(wb_data_i),
        .operand_o(operand[0])
    );

    operand_forward u_fwd_0_1 (
        .read_en_i(reg_read_en_i[0][1]), .read_addr_i(reg_read_addr_i[0][1]),
        .rf_data_i(rf_data_i[1]), .imm_i(imm_i[0]),
        .ex_we_i(ex_we_i), .ex_addr_i(ex_addr_i), .ex_data_i(ex_data_i),
        .mem_we_i(mem_we_i), .mem_addr_i(mem_addr_i), .mem_data_i(mem_data_i),
        .wb_we_i(wb_we_i), .wb_addr_i(wb_addr_i), .wb_data_i(wb_data_i),
        .operand_o(operand[1])
    );

    operand_forward u_fwd_1_0 (
        .read_en_i(reg_read_en_i[1][0]), .read_addr_i(reg_read_addr_i[1][0]),
        .rf_data_i(rf_data_i[2]), .imm_i(imm_i[1]),
        .ex_we_i(ex_we_i), .ex_addr_i(ex_addr_i), .ex_data_i(ex_data_i),
        .mem_we_i(mem_we_i), .mem_addr_i(mem_addr_i), .mem_data_i(mem_data_i),
        .wb_we_i(wb_we_i), .wb_addr_i(wb_addr_i), .wb_data_i(wb_data_i),
        .operand_o(operand[2])
    );

    operand_forward u_fwd_1_1 (
        .read_en_i(reg_read_en_i[1][1]), .read_addr_i(reg_read_addr_i[1][1]),
        .rf_data_i(rf_data_i[3]), .imm_i(imm_i[1]),
        .ex_we_i(ex_we_i), .ex_addr_i(ex_addr_i), .ex_data_i(ex_data_i),
        .mem_we_i(mem_we_i), .mem_addr_i(mem_addr_i), .mem_data_i(mem_data_i),
        .wb_we_i(wb_we_i), .wb_addr_i(wb_addr_i), .wb_data_i(wb_data_i),
        .operand_o(operand[3])
    );

    load_use_detect u_load_use (
        .ex_alu_op_i(ex_alu_op_i), .ex_addr0_i(ex_addr_i[0]),
        .read_en_i(reg_read_en_i), .read_addr_i(reg_read_addr_i),  // flattened slot*2 + source
        .load_use_o(load_use)
    );

    dispatch_stage_reg u_stage_reg (
        .clk(clk), .reset_i(reset_i), .issue_en_i(issue_en), .valid_i(valid_i),
        .pc_i(pc_i), .inst_i(inst_i), .alu_op_i(alu_op_i), .alu_sel_i(alu_sel_i),
        .reg_write_en_i(reg_write_en_i), .reg_write_addr_i(reg_write_addr_i),
        .operand_i(operand), .load_use_i(load_use), .ex_pause_i(ex_pause_i),
        .pause_i(pause_i), .flush_i(flush_i),
        .pc_o(pc_o), .inst_o(inst_o), .valid_o(valid_o), .alu_op_o(alu_op_o),
        .alu_sel_o(alu_sel_o), .reg_write_en_o(reg_write_en_o),
        .reg_write_addr_o(reg_write_addr_o), .operand_o(operand_o)
    );

endmodule

`default_nettype wire

// File: dispatch/dispatch_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage_reg
    import dispatch_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_i,
    input  slot_mask_t                 issue_en_i,   // before the pause gating
    input  slot_mask_t                 valid_i,
    input  word_t      [NUM_SLOTS-1:0] pc_i,
    input  word_t      [NUM_SLOTS-1:0] inst_i,
    input  alu_op_t    [NUM_SLOTS-1:0] alu_op_i,
    input  alu_sel_t   [NUM_SLOTS-1:0] alu_sel_i,
    input  slot_mask_t                 reg_write_en_i,
    input  reg_addr_t  [NUM_SLOTS-1:0] reg_write_addr_i,
    input  word_t      [3:0]           operand_i,    // slot*2 + source
    input  logic                       load_use_i,
    input  logic                       ex_pause_i,
    input  logic                       pause_i,
    input  logic                       flush_i,
    output word_t      [NUM_SLOTS-1:0] pc_o,
    output word_t      [NUM_SLOTS-1:0] inst_o,
    output slot_mask_t                 valid_o,
    output alu_op_t    [NUM_SLOTS-1:0] alu_op_o,
    output alu_sel_t   [NUM_SLOTS-1:0] alu_sel_o,
    output slot_mask_t                 reg_write_en_o,
    output reg_addr_t  [NUM_SLOTS-1:0] reg_write_addr_o,
    output word_t      [3:0]           operand_o
);

    logic bubble;

    // a stalled ex keeps its load, so no bubble is needed then
    assign bubble = load_use_i && !ex_pause_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i || bubble) begin
            pc_o             <= '0;
            inst_o           <= '0;
            valid_o          <= '0;
            alu_op_o         <= '0;
            alu_sel_o        <= '0;
            reg_write_en_o   <= '0;
            reg_write_addr_o <= '0;
            operand_o        <= '0;
        end else if (!pause_i) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (issue_en_i[s]) begin
                    pc_o[s]             <= pc_i[s];
                    inst_o[s]           <= inst_i[s];
                    valid_o[s]          <= valid_i[s];
                    alu_op_o[s]         <= alu_op_i[s];
                    alu_sel_o[s]        <= alu_sel_i[s];
                    reg_write_en_o[s]   <= reg_write_en_i[s];
                    reg_write_addr_o[s] <= reg_write_addr_i[s];
                    operand_o[2*s]      <= operand_i[2*s];
                    operand_o[2*s+1]    <= operand_i[2*s+1];
                end else begin
                    pc_o[s]             <= '0;  // slot left behind, send a nop
                    inst_o[s]           <= '0;
                    valid_o[s]          <= 1'b0;
                    alu_op_o[s]         <= '0;
                    alu_sel_o[s]        <= '0;
                    reg_write_en_o[s]   <= 1'b0;
                    reg_write_addr_o[s] <= '0;
                    operand_o[2*s]      <= '0;
                    operand_o[2*s+1]    <= '0;
                end
            end
        end
        // pause_i high: everything holds
    end

endmodule

`default_nettype wire

// File: dispatch/load_use_detect.sv
`timescale 1ns/1ps
`default_nettype none

module load_use_detect
    import dispatch_pkg::*;
(
    input  alu_op_t   [NUM_SLOTS-1:0] ex_alu_op_i,
    input  reg_addr_t                 ex_addr0_i,   // load result always sits in entry 0
    input  logic      [3:0]           read_en_i,    // index is slot*2 + source
    input  reg_addr_t [3:0]           read_addr_i,
    output logic                      load_use_o
);

    logic ex_load;
    logic [3:0] dep;

    assign ex_load = is_load_op(ex_alu_op_i[0]) || is_load_op(ex_alu_op_i[1]);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            dep[i] = read_en_i[i] && (read_addr_i[i] == ex_addr0_i);
        end
    end

    // data arrives after mem, forwarding from ex is too early
    assign load_use_o = ex_load && (|dep);

endmodule

`default_nettype wire

// File: dispatch/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward
    import dispatch_pkg::*;
(
    input  logic                       read_en_i,
    input  reg_addr_t                  read_addr_i,
    input  word_t                      rf_data_i,
    input  word_t                      imm_i,
    input  slot_mask_t                 ex_we_i,
    input  reg_addr_t  [NUM_SLOTS-1:0] ex_addr_i,
    input  word_t      [NUM_SLOTS-1:0] ex_data_i,
    input  slot_mask_t                 mem_we_i,
    input  reg_addr_t  [NUM_SLOTS-1:0] mem_addr_i,
    input  word_t      [NUM_SLOTS-1:0] mem_data_i,
    input  slot_mask_t                 wb_we_i,
    input  reg_addr_t  [NUM_SLOTS-1:0] wb_addr_i,
    input  word_t      [NUM_SLOTS-1:0] wb_data_i,
    output word_t                      operand_o
);

    slot_mask_t ex_hit;
    slot_mask_t mem_hit;
    slot_mask_t wb_hit;

    // address matches per stage entry
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            ex_hit[i]  = ex_we_i[i]  && (ex_addr_i[i]  == read_addr_i);
            mem_hit[i] = mem_we_i[i] && (mem_addr_i[i] == read_addr_i);
            wb_hit[i]  = wb_we_i[i]  && (wb_addr_i[i]  == read_addr_i);
        end
    end

    // youngest producer wins, entry 0 before entry 1 inside a stage
    always_comb begin
        if (!read_en_i) begin
            operand_o = imm_i;  // no register read, immediate operand
        end else if (read_addr_i == '0) begin
            operand_o = '0;  // r0 is hardwired
        end else if (ex_hit[0]) begin
            operand_o = ex_data_i[0];
        end else if (ex_hit[1]) begin
            operand_o = ex_data_i[1];
        end else if (mem_hit[0]) begin
            operand_o = mem_data_i[0];
        end else if (mem_hit[1]) begin
            operand_o = mem_data_i[1];
        end else if (wb_hit[0]) begin
            operand_o = wb_data_i[0];
        end else if (wb_hit[1]) begin
            operand_o = wb_data_i[1];
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

// File: dispatch/issue_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module issue_arbiter
    import dispatch_pkg::*;
(
    input  slot_mask_t                      valid_i,
    input  alu_sel_t   [NUM_SLOTS-1:0]      alu_sel_i,
    input  slot_mask_t                      reg_write_en_i,
    input  reg_addr_t  [NUM_SLOTS-1:0]      reg_write_addr_i,
    input  logic       [1:0]                slot1_read_en_i,    // per source of slot 1
    input  reg_addr_t  [1:0]                slot1_read_addr_i,
    input  slot_mask_t                      is_privilege_i,
    input  slot_mask_t                      is_cnt_i,
    output slot_mask_t                      issue_en_o
);

    logic mem_inst;
    logic priv_inst;
    logic cnt_inst;
    logic raw_hazard;
    logic dual_ok;
    logic slot0_writes;

    assign mem_inst  = (alu_sel_i[0] == ALU_SEL_LOAD_STORE) ||
                       (alu_sel_i[1] == ALU_SEL_LOAD_STORE);  // memory ops go alone
    assign priv_inst = |is_privilege_i;
    assign cnt_inst  = |is_cnt_i;

    // slot 1 can't see slot 0's result in the same cycle
    assign slot0_writes = reg_write_en_i[0] && (reg_write_addr_i[0] != '0);
    assign raw_hazard   = slot0_writes &&
                          ((slot1_read_en_i[0] && slot1_read_addr_i[0] == reg_write_addr_i[0]) ||
                           (slot1_read_en_i[1] && slot1_read_addr_i[1] == reg_write_addr_i[0]));

    assign dual_ok = (&valid_i) && !mem_inst && !priv_inst && !cnt_inst && !raw_hazard;

    always_comb begin
        if (dual_ok) begin
            issue_en_o = 2'b11;
        end else if (valid_i[0]) begin
            issue_en_o = 2'b01;  // oldest first
        end else if (valid_i[1]) begin
            issue_en_o = 2'b10;
        end else begin
            issue_en_o = 2'b00;
        end
    end

endmodule

`default_nettype wire

// File: common/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    localparam int NUM_SLOTS = 2;  // issue slots per cycle

    typedef logic [31:0]          word_t;       // pc, inst, imm, operands
    typedef logic [4:0]           reg_addr_t;   // architectural register index
    typedef logic [7:0]           alu_op_t;
    typedef logic [2:0]           alu_sel_t;    // functional class
    typedef logic [NUM_SLOTS-1:0] slot_mask_t;  // one bit per slot

    localparam alu_sel_t ALU_SEL_LOAD_STORE = 3'b111;  // memory class

    // load-type opcodes, sc.w counts since it returns a value
    localparam alu_op_t ALU_LD_B  = 8'h28;
    localparam alu_op_t ALU_LD_H  = 8'h29;
    localparam alu_op_t ALU_LD_W  = 8'h2a;
    localparam alu_op_t ALU_LD_BU = 8'h2b;
    localparam alu_op_t ALU_LD_HU = 8'h2c;
    localparam alu_op_t ALU_LL_W  = 8'h30;
    localparam alu_op_t ALU_SC_W  = 8'h31;

    function automatic logic is_load_op(input alu_op_t op);
        logic hit;
        case (op)
            ALU_LD_B,
            ALU_LD_H,
            ALU_LD_W,
            ALU_LD_BU,
            ALU_LD_HU,
            ALU_LL_W,
            ALU_SC_W: hit = 1'b1;
            default:  hit = 1'b0;
        endcase
        return hit;
    endfunction

endpackage

`default_nettype wire
